//--- rtl/DacSerializer.sv
//----------------------------
// Serial DAC driver, 16 bit frames MSB first
// Scales each accepted sample by 16 and shifts it out on sclk, syncN, din
// Samples arriving mid frame are dropped
//----------------------------
`timescale 1ns/1ns

module DacSerializer #(
	parameter int SclkDivisor = boardPkg::DefaultSclkDivisor
) (
	input  logic clock_50Mhz,
	input  logic reset,
	input  audioPkg::sampleBeat_s beat,
	output logic sclk,
	output logic syncN,
	output logic din
);
	import audioPkg::*;

	localparam int DivWidth = $clog2(SclkDivisor + 1);
	localparam logic [DivWidth-1:0] DivLast = DivWidth'(SclkDivisor - 1);
	localparam int BitWidth = $clog2(FrameWidth);
	localparam logic [BitWidth-1:0] BitLast = BitWidth'(FrameWidth - 1);

	dacFrame_u frame;               // Loaded as fields, shifted as raw
	logic busy;                     // High for the whole frame
	logic accept;
	logic [DivWidth-1:0] divCount;  // Half period counter
	logic halfDone;
	logic [BitWidth-1:0] bitCount;  // Bits already shifted out
	dacWord_t scaled;

	// Sample x16 fills the 12 bit DAC range
	assign scaled = {beat.sample, {(DacWidth - SampleWidth){1'b0}}};
	assign accept = beat.strobe & ~busy; // Busy drops the strobe
	assign halfDone = (divCount == DivLast);

	//----------------------------
	// Frame register
	//----------------------------
	always_ff @(posedge clock_50Mhz) begin
		if (accept) begin
			frame.fields.control <= DacControlNormal;
			frame.fields.data <= scaled;
		end else if (busy && halfDone && sclk) begin
			frame.raw <= {frame.raw[FrameWidth-2:0], 1'b0}; // Next bit on falling sclk
		end
	end

	//----------------------------
	// sclk, bit count, syncN
	//----------------------------
	always_ff @(posedge clock_50Mhz) begin
		if (reset) begin
			busy <= 1'b0;
			syncN <= 1'b1;
			sclk <= 1'b0;
			divCount <= '0;
			bitCount <= '0;
		end else if (accept) begin
			busy <= 1'b1;
			syncN <= 1'b0; // Frame starts one clock after the strobe
			sclk <= 1'b0;
			divCount <= '0;
			bitCount <= '0;
		end else if (busy) begin
			if (halfDone) begin
				divCount <= '0;
				sclk <= ~sclk;
				if (sclk) begin
					// Falling edge ends a bit
					if (bitCount == BitLast) begin
						busy <= 1'b0; // 16th bit done, back to idle
						syncN <= 1'b1;
					end else begin
						bitCount <= bitCount + 1'b1;
					end
				end
			end else begin
				divCount <= divCount + 1'b1;
			end
		end
	end

	// MSB of the shift word, low while idle
	assign din = busy & frame.raw[FrameWidth-1];

endmodule

//--- rtl/InputConditioner.sv
//----------------------------
// Debounce for the six music keys and the bee mode button
// Outputs active high held levels plus the toggled bee mode level
//----------------------------
`timescale 1ns/1ns

module InputConditioner #(
	parameter int DebounceCycles = boardPkg::DefaultDebounceCycles
) (
	input  logic clock_50Mhz,
	input  logic reset,
	input  logic [boardPkg::KeyCount-1:0] musicKeys_n,
	input  logic beeButton_n,
	output boardPkg::uiControls_s controls
);
	import boardPkg::*;

	localparam int InputCount = KeyCount + 1;                // Keys plus bee button
	localparam int CountWidth = $clog2(DebounceCycles + 1);
	localparam logic [CountWidth-1:0] CountLast = CountWidth'(DebounceCycles - 1);

	logic [InputCount-1:0] rawInputs_n; // Bee button on top
	logic [InputCount-1:0] pressed;     // Debounced, active high
	logic beePrev;
	logic beePress;
	logic beeMode;

	assign rawInputs_n = {beeButton_n, musicKeys_n};

	//----------------------------
	// Per input debounce
	//----------------------------
	for (genvar i = 0; i < InputCount; i++) begin : gDebounce
		logic [1:0] syncFf;               // Two flop synchronizer
		logic [CountWidth-1:0] stableCount;
		logic level_n;                    // Debounced, still active low

		always_ff @(posedge clock_50Mhz) begin
			if (reset) begin
				syncFf <= 2'b11;     // Released
				stableCount <= '0;
				level_n <= 1'b1;
			end else begin
				syncFf <= {syncFf[0], rawInputs_n[i]};
				if (syncFf[1] == level_n) begin
					stableCount <= '0; // Agrees with output, nothing pending
				end else if (stableCount == CountLast) begin
					level_n <= syncFf[1]; // New level held long enough
					stableCount <= '0;
				end else begin
					stableCount <= stableCount + 1'b1;
				end
			end
		end

		assign pressed[i] = ~level_n;
	end

	//----------------------------
	// Bee mode toggle
	//----------------------------
	// Released to pressed edge of the debounced button
	assign beePress = pressed[KeyCount] & ~beePrev;

	always_ff @(posedge clock_50Mhz) begin
		if (reset) begin
			beePrev <= 1'b0;
			beeMode <= 1'b0; // Square wave after reset
		end else begin
			beePrev <= pressed[KeyCount];
			if (beePress) begin
				beeMode <= ~beeMode;
			end
		end
	end

	assign controls.keysHeld = pressed[KeyCount-1:0];
	assign controls.beeMode = beeMode;

endmodule

//--- rtl/MusicBoxTop.sv
//----------------------------
// Music box audio path, buttons to serial DAC
// Chains input conditioning, tone synthesis and the DAC serializer
// Divisors are parameters so simulation can shrink them
//----------------------------
`timescale 1ns/1ns

module MusicBoxTop #(
	parameter int DebounceCycles = boardPkg::DefaultDebounceCycles,
	parameter int SampleDivisor = boardPkg::DefaultSampleDivisor,
	parameter int SclkDivisor = boardPkg::DefaultSclkDivisor
) (
	input  logic clock_50Mhz,
	input  logic reset,                                 // Synchronous, active high
	input  logic [boardPkg::KeyCount-1:0] musicKeys_n,  // Active low keys
	input  logic beeButton_n,                           // Active low
	output logic beeModeLed,
	output logic sclk,
	output logic syncN,
	output logic din
);
	import boardPkg::*;
	import audioPkg::*;

	uiControls_s controls; // Debounced levels into the synth
	sampleBeat_s beat;     // Sample and strobe into the serializer

	//----------------------------
	// Button conditioning
	//----------------------------
	InputConditioner #(
		.DebounceCycles(DebounceCycles)
	) inputConditioner (
		.clock_50Mhz(clock_50Mhz),
		.reset(reset),
		.musicKeys_n(musicKeys_n),
		.beeButton_n(beeButton_n),
		.controls(controls)
	);

	assign beeModeLed = controls.beeMode; // LED follows the toggled level

	//----------------------------
	// Tone generation
	//----------------------------
	ToneSynth #(
		.SampleDivisor(SampleDivisor)
	) toneSynth (
		.clock_50Mhz(clock_50Mhz),
		.reset(reset),
		.controls(controls),
		.beat(beat)
	);

	//----------------------------
	// DAC output
	//----------------------------
	DacSerializer #(
		.SclkDivisor(SclkDivisor)
	) dacSerializer (
		.clock_50Mhz(clock_50Mhz),
		.reset(reset),
		.beat(beat),
		.sclk(sclk),
		.syncN(syncN),
		.din(din)
	);

endmodule

//--- rtl/ToneSynth.sv
//----------------------------
// Tone synthesizer, one 8 bit sample per sample tick
// Lowest held key picks the note, bee mode picks triangle over square
// No key held gives silence
//----------------------------
`timescale 1ns/1ns

module ToneSynth #(
	parameter int SampleDivisor = boardPkg::DefaultSampleDivisor
) (
	input  logic clock_50Mhz,
	input  logic reset,
	input  boardPkg::uiControls_s controls,
	output audioPkg::sampleBeat_s beat
);
	import boardPkg::*;
	import audioPkg::*;

	localparam int TickWidth = $clog2(SampleDivisor + 1);
	localparam logic [TickWidth-1:0] TickLast = TickWidth'(SampleDivisor - 1);
	localparam int KeyIndexWidth = $clog2(KeyCount);
	localparam int PhaseWidth = 8; // Fits the longest half period

	// Triangle step per tick so the ramp reaches full scale within a half period
	function automatic logic [KeyCount-1:0][7:0] buildRampSteps();
		logic [KeyCount-1:0][7:0] steps;
		int halfTicks;
		for (int k = 0; k < KeyCount; k++) begin
			halfTicks = int'(NoteHalfPeriods[k]) - 1;
			steps[k] = 8'((255 + halfTicks - 1) / halfTicks); // Round up
		end
		return steps;
	endfunction

	localparam logic [KeyCount-1:0][7:0] RampSteps = buildRampSteps();

	logic [TickWidth-1:0] tickCount;
	logic tick;
	logic anyKey;
	logic [KeyIndexWidth-1:0] chosenKey;   // Lowest held key
	logic [KeyIndexWidth-1:0] activeKey;   // Key the phase belongs to
	logic keyActive;
	logic [PhaseWidth-1:0] phase;
	logic [PhaseWidth-1:0] nextPhase;
	logic waveHalf;                        // 0 = first half of the period
	logic nextHalf;
	logic [15:0] ramp;
	sample_t rampClamped;
	sample_t nextSample;

	//----------------------------
	// Sample tick divider
	//----------------------------
	assign tick = (tickCount == TickLast);

	always_ff @(posedge clock_50Mhz) begin
		if (reset) begin
			tickCount <= '0;
		end else begin
			tickCount <= tick ? '0 : tickCount + 1'b1;
		end
	end

	// Descending scan so the lowest held key wins
	always_comb begin
		anyKey = |controls.keysHeld;
		chosenKey = '0;
		for (int k = KeyCount - 1; k >= 0; k--) begin
			if (controls.keysHeld[k]) chosenKey = KeyIndexWidth'(k);
		end
	end

	//----------------------------
	// Note phase and waveform
	//----------------------------
	always_comb begin
		nextPhase = phase + 1'b1;
		nextHalf = waveHalf;
		if (!anyKey || !keyActive || chosenKey != activeKey) begin
			nextPhase = '0;  // Silence or new note restarts the period
			nextHalf = 1'b0;
		end else if (phase == NoteHalfPeriods[chosenKey] - 1'b1) begin
			nextPhase = '0;  // Wrap, next half
			nextHalf = ~waveHalf;
		end

		ramp = {8'd0, nextPhase} * {8'd0, RampSteps[chosenKey]};
		rampClamped = (ramp > 16'd255) ? 8'd255 : ramp[7:0];

		if (!anyKey) begin
			nextSample = '0;
		end else if (controls.beeMode) begin
			nextSample = nextHalf ? 8'd255 - rampClamped : rampClamped; // Triangle
		end else begin
			nextSample = nextHalf ? 8'd0 : 8'd255; // Square
		end
	end

	always_ff @(posedge clock_50Mhz) begin
		if (reset) begin
			keyActive <= 1'b0;
			activeKey <= '0;
			phase <= '0;
			waveHalf <= 1'b0;
			beat.sample <= '0;
			beat.strobe <= 1'b0;
		end else begin
			beat.strobe <= tick; // Exactly one clock per tick
			if (tick) begin
				keyActive <= anyKey;
				activeKey <= chosenKey;
				phase <= nextPhase;
				waveHalf <= nextHalf;
				beat.sample <= nextSample;
			end
		end
	end

endmodule

//--- rtl/audioPkg.sv
//----------------------------
// Audio path definitions
// Sample and DAC word types, the note table and the DAC frame layout
// Shared by the synth and the serializer
//----------------------------

package audioPkg;

	//----------------------------
	// Widths
	//----------------------------
	localparam int SampleWidth = 8;  // Synth output
	localparam int DacWidth = 12;    // DAC resolution
	localparam int FrameWidth = 16;  // One SPI frame

	typedef logic [SampleWidth-1:0] sample_t; // Unsigned, 0 is silence
	typedef logic [DacWidth-1:0] dacWord_t;

	//----------------------------
	// Note table
	//----------------------------
	// Half periods in sample ticks at 32 kHz
	// Index 0 is the lowest note, so the longest half period
	localparam logic [boardPkg::KeyCount-1:0][7:0] NoteHalfPeriods = {
		8'd36, // Key 5, A4
		8'd41, // Key 4, G4
		8'd46, // Key 3, F4
		8'd48, // Key 2, E4
		8'd54, // Key 1, D4
		8'd61  // Key 0, C4
	};

	//----------------------------
	// DAC frame
	//----------------------------
	localparam logic [3:0] DacControlNormal = 4'b0000; // Normal operation, no power down

	typedef struct packed {
		logic [3:0] control; // Upper nibble, shifted out first
		dacWord_t data;
	} dacFields_s;

	// Built through the fields, shifted through raw
	typedef union packed {
		dacFields_s fields;
		logic [FrameWidth-1:0] raw;
	} dacFrame_u;

	// Sample with its new-sample pulse
	typedef struct packed {
		sample_t sample;
		logic strobe; // One clock per sample tick
	} sampleBeat_s;

endpackage

//--- rtl/boardPkg.sv
//----------------------------
// Board level definitions for the music box
// Key count, default timebase divisors and the conditioned button bundle
// Imported by the input stage, the synth and the top level
//----------------------------

package boardPkg;

	//----------------------------
	// Board inputs
	//----------------------------
	localparam int KeyCount = 6; // Six music keys on the GPIO header

	//----------------------------
	// Default timebases at 50 MHz
	//----------------------------
	// Input must hold this many clocks to count as settled
	localparam int DefaultDebounceCycles = 50000; // 1 ms

	// Clocks between sample ticks
	localparam int DefaultSampleDivisor = 1563; // ~32 kHz sample rate

	// Clocks per sclk half period
	localparam int DefaultSclkDivisor = 50; // 500 kHz sclk

	//----------------------------
	// Conditioned button levels
	//----------------------------
	// Both fields are plain levels, active high
	typedef struct packed {
		logic [KeyCount-1:0] keysHeld; // 1 = key held down
		logic beeMode;                 // Toggled by each bee button press
	} uiControls_s;

endpackage

//--- run.sh
#!/bin/sh
# Build and run the music box testbench with Verilator
set -e

verilator --binary --timing --assert \
	-f vlog.f \
	--top-module MusicBoxTb \
	-o simv

simOut=$(./obj_dir/simv +verilator+error+limit+1000)
echo "$simOut"

# Pass only if the testbench printed its pass line
echo "$simOut" | grep -q "^TEST RESULT: PASS$"

//--- testbench/MusicBoxChecker_checker.sv
//----------------------------
// Bound checker for the music box pins
// Rebuilds each DAC frame from din and checks format and content
// failCount is read by the testbench at the end of the run
//----------------------------
`timescale 1ns/1ns

module MusicBoxChecker #(
	parameter int SampleDivisor = boardPkg::DefaultSampleDivisor,
	parameter int DebounceCycles = boardPkg::DefaultDebounceCycles
) (
	input logic clock_50Mhz,
	input logic reset,
	input logic beeButton_n,
	input boardPkg::uiControls_s controls,
	input logic beeModeLed,
	input logic sclk,
	input logic syncN,
	input logic din
);
	import boardPkg::*;
	import audioPkg::*;

	localparam int SettleClocks = 2 * SampleDivisor; // Covers tick to frame latency
	// Largest triangle change per tick, full ramp over the shortest half period
	localparam int MaxTriangleStep = 16 * (255 / (int'(NoteHalfPeriods[KeyCount-1]) - 1) + 1);

	int failCount = 0;
	logic prevSclk = 1'b0;
	logic prevSync = 1'b1;
	logic [FrameWidth-1:0] shiftReg = '0;  // Frame as seen on din
	int bitsSeen = 0;
	int quietCount = 0;      // Clocks with no key held
	int steadyCount = 0;     // Clocks of one key set in square mode
	int triangleCount = 0;   // Clocks of one key set in bee mode
	int beeLowRun = 0;       // Raw bee button low run
	uiControls_s prevControls = '0;
	logic startQuiet = 1'b0;
	logic startSquare = 1'b0;
	logic startTriangle = 1'b0;
	logic prevTriangle = 1'b0;  // Frame before was steady triangle too
	dacWord_t lastData = '0;    // Data of the frame before
	logic frameDone;
	dacWord_t frameData;
	dacWord_t dataStep;

	assign frameDone = !reset && !prevSync && syncN; // syncN rising ends a frame
	assign frameData = shiftReg[DacWidth-1:0];
	assign dataStep = (frameData > lastData) ? frameData - lastData : lastData - frameData;

	//----------------------------
	// Frame rebuild and history
	//----------------------------
	always @(posedge clock_50Mhz) begin
		prevSclk <= sclk;
		prevSync <= syncN;
		prevControls <= controls;
		if (prevSync && !syncN) begin
			bitsSeen <= 0;
			startQuiet <= (quietCount >= SettleClocks);
			startSquare <= (steadyCount >= SettleClocks);
			startTriangle <= (triangleCount >= SettleClocks);
		end else if (!syncN && sclk && !prevSclk) begin
			shiftReg <= {shiftReg[FrameWidth-2:0], din}; // MSB first
			bitsSeen <= bitsSeen + 1;
		end
		if (frameDone) begin
			lastData <= frameData;
			prevTriangle <= startTriangle;
		end
		quietCount <= (|controls.keysHeld) ? 0 : quietCount + 1;
		if (controls != prevControls || controls.beeMode || !(|controls.keysHeld))
			steadyCount <= 0;
		else
			steadyCount <= steadyCount + 1;
		if (controls != prevControls || !controls.beeMode || !(|controls.keysHeld))
			triangleCount <= 0;
		else
			triangleCount <= triangleCount + 1;
		beeLowRun <= beeButton_n ? 0 : beeLowRun + 1;
	end

	//----------------------------
	// Assertions
	//----------------------------
	resetState: assert property (@(posedge clock_50Mhz)
		$past(reset) |-> syncN && !sclk && !beeModeLed)
		else begin $error("** Error at %0t: pins not idle in reset", $time); failCount++; end

	frameLength: assert property (@(posedge clock_50Mhz) frameDone |-> bitsSeen == FrameWidth)
		else begin $error("** Error at %0t: frame bit count wrong", $time); failCount++; end

	frameFormat: assert property (@(posedge clock_50Mhz)
		frameDone |-> shiftReg[FrameWidth-1:DacWidth] == DacControlNormal && shiftReg[3:0] == 4'd0)
		else begin
			$error("** Error at %0t: frame control or low bits wrong", $time);
			failCount++;
		end

	silence: assert property (@(posedge clock_50Mhz) frameDone && startQuiet |-> frameData == 0)
		else begin $error("** Error at %0t: silent frame not zero", $time); failCount++; end

	squareTone: assert property (@(posedge clock_50Mhz)
		frameDone && startSquare |-> frameData == 0 || frameData == 12'd4080)
		else begin $error("** Error at %0t: square frame not 0 or 4080", $time); failCount++; end

	// Triangle stays in range and moves by at most one ramp step per frame
	triangleRange: assert property (@(posedge clock_50Mhz)
		frameDone && startTriangle |-> frameData <= 12'd4080 &&
			(!prevTriangle || dataStep <= MaxTriangleStep))
		else begin
			$error("** Error at %0t: triangle frame out of range or step too large", $time);
			failCount++;
		end

	// A flip needs a press longer than the debounce time
	beeToggle: assert property (@(posedge clock_50Mhz)
		!reset && !$past(reset) && beeModeLed != $past(beeModeLed) |-> beeLowRun >= DebounceCycles)
		else begin
			$error("** Error at %0t: bee mode flipped without a full press", $time);
			failCount++;
		end

endmodule

bind MusicBoxTop MusicBoxChecker #(
	.SampleDivisor(SampleDivisor),
	.DebounceCycles(DebounceCycles)
) frameCheck (
	.clock_50Mhz(clock_50Mhz),
	.reset(reset),
	.beeButton_n(beeButton_n),
	.controls(controls),
	.beeModeLed(beeModeLed),
	.sclk(sclk),
	.syncN(syncN),
	.din(din)
);

//--- testbench/MusicBoxTb.sv
//----------------------------
// Testbench for the music box audio path
// Drives keys and the bee button, the bound checker does the checking
//----------------------------
`timescale 1ns/1ns

module MusicBoxTb;
	import boardPkg::*;

	localparam int DebounceCycles = 4;
	localparam int SampleDivisor = 40;
	localparam int SclkDivisor = 1;
	localparam int FrameTimeout = 4 * SampleDivisor + 100; // Clocks to wait for a frame end
	localparam int LedTimeout = 200;

	logic clock_50Mhz;
	logic reset;
	logic [KeyCount-1:0] musicKeys_n;
	logic beeButton_n;
	logic beeModeLed;
	logic sclk;
	logic syncN;
	logic din;

	int timeoutCount = 0;
	logic [31:0] lcgState = 32'hbdf3;

	MusicBoxTop #(
		.DebounceCycles(DebounceCycles),
		.SampleDivisor(SampleDivisor),
		.SclkDivisor(SclkDivisor)
	) DUT (
		.clock_50Mhz(clock_50Mhz),
		.reset(reset),
		.musicKeys_n(musicKeys_n),
		.beeButton_n(beeButton_n),
		.beeModeLed(beeModeLed),
		.sclk(sclk),
		.syncN(syncN),
		.din(din)
	);

	initial begin
		clock_50Mhz = 1'b0;
		forever #5 clock_50Mhz = ~clock_50Mhz; // 10 ns period
	end

	//----------------------------
	// Helpers
	//----------------------------
	function automatic logic [31:0] nextRandom();
		lcgState = lcgState * 32'd1103515245 + 32'd12345;
		return lcgState;
	endfunction

	task automatic idleClocks(input int n);
		repeat (n) @(posedge clock_50Mhz);
	endtask

	// Wait for syncN to rise, counting a timeout
	task automatic waitFrameEnd();
		int waited;
		logic seenLow;
		waited = 0;
		seenLow = 1'b0;
		while (waited < FrameTimeout) begin
			@(posedge clock_50Mhz);
			if (!syncN) seenLow = 1'b1;
			else if (seenLow) break;
			waited++;
		end
		if (waited >= FrameTimeout) begin
			$display("Timeout at %0t: no DAC frame finished", $time);
			timeoutCount++;
		end
	endtask

	task automatic holdFrames(input int n);
		repeat (n) waitFrameEnd();
	endtask

	task automatic driveKeys(input logic [KeyCount-1:0] keys_n);
		@(posedge clock_50Mhz);
		#1 musicKeys_n = keys_n;
	endtask

	// Press the bee button for a number of clocks, then release
	task automatic pulseBee(input int clocks);
		@(posedge clock_50Mhz);
		#1 beeButton_n = 1'b0;
		idleClocks(clocks);
		#1 beeButton_n = 1'b1;
	endtask

	task automatic waitLedLevel(input logic level);
		int waited;
		waited = 0;
		while (beeModeLed !== level && waited < LedTimeout) begin
			@(posedge clock_50Mhz);
			waited++;
		end
		if (beeModeLed !== level) begin
			$display("Timeout at %0t: bee mode LED did not change", $time);
			timeoutCount++;
		end
	endtask

	// One key held long enough for both wave halves
	task automatic playRandomKey(input int baseFrames);
		int key;
		int frames;
		key = int'(nextRandom() % KeyCount);
		frames = baseFrames + int'(nextRandom() % 32);
		driveKeys(~(KeyCount'(1) << key));
		holdFrames(frames);
		driveKeys('1);
		holdFrames(4);
	endtask

	//----------------------------
	// Stimulus
	//----------------------------
	initial begin
		int failures;
		reset = 1'b1;
		musicKeys_n = '1;
		beeButton_n = 1'b1;
		idleClocks(4);
		#1 reset = 1'b0;

		holdFrames(6); // Silence

		for (int r = 0; r < 3; r++) begin
			playRandomKey(140); // Square
		end

		pulseBee(2); // Too short to count
		idleClocks(20);
		pulseBee(DebounceCycles + 6);
		waitLedLevel(1'b1);
		idleClocks(DebounceCycles + 6);

		for (int r = 0; r < 2; r++) begin
			playRandomKey(140); // Triangle
		end

		pulseBee(DebounceCycles + 6);
		waitLedLevel(1'b0);
		idleClocks(DebounceCycles + 6);
		playRandomKey(130);

		failures = DUT.frameCheck.failCount;
		$display("Checker failures: %0d, timeouts: %0d", failures, timeoutCount);
		if (failures == 0 && timeoutCount == 0) begin
			$display("TEST RESULT: PASS");
		end else begin
			$display("TEST RESULT: FAIL");
		end
		$finish;
	end

endmodule

//--- vlog.f
rtl/boardPkg.sv
rtl/audioPkg.sv
rtl/InputConditioner.sv
rtl/ToneSynth.sv
rtl/DacSerializer.sv
rtl/MusicBoxTop.sv
testbench/MusicBoxChecker_checker.sv
testbench/MusicBoxTb.sv
